/* list.f */
rtl/mmuPkg.sv
rtl/tlb.sv
rtl/pmaChecker.sv
rtl/pmpChecker.sv
rtl/mmu.sv
verification/mmu_asserts.sv
verification/mmuTb.sv

/* rtl/mmu.sv */
// Sv32 MMU top level; translates through the TLB, runs PMA/PMP checks and merges the faults
module mmu (
  input  logic                                       clk,
  input  logic                                       reset,
  input  logic [mmuPkg::xlen-1:0]                    satp,               // Mode and ASID used
  input  logic                                       statusMxr,
  input  logic                                       statusSum,
  input  mmuPkg::privModeT                           privilegeMode,
  input  logic                                       disableTranslation, // Walker and flush use PA
  input  mmuPkg::vAdrT                               vAdr,
  input  mmuPkg::accessSizeT                         size,
  input  mmuPkg::pteT                                pte,
  input  logic                                       pageTypeWriteVal,   // Megapage refill
  input  logic                                       tlbWrite,
  input  logic                                       tlbFlush,
  input  logic                                       executeAccess,
  input  logic                                       readAccess,
  input  logic                                       writeAccess,
  input  logic                                       atomicAccess,
  input  mmuPkg::pmpCfgT  [mmuPkg::pmpEntries-1:0]   pmpCfg,
  input  mmuPkg::pmpAddrT [mmuPkg::pmpEntries-1:0]   pmpAddr,
  output mmuPkg::pAdrT                               physicalAddress,
  output logic                                       cacheable,
  output logic                                       idempotent,
  output mmuPkg::mmuFaultsT                          faults
);
  import mmuPkg::*;

  logic       translate;
  ppnT        tlbPpn;
  logic       tlbHit, tlbMiss, tlbPageFault;
  logic       adrValid;                     // PA is meaningful this cycle
  logic [2:0] pmaFaults, pmpFaults;
  logic [2:0] accessFaults;
  logic       dataMisaligned;
  logic       readNoAmo;                    // AMOs fault as stores

  // Machine mode and bare satp bypass
  assign translate = satp[satpModeBit] & (privilegeMode != privMachine) & ~disableTranslation;

  tlb tlb_inst (
    .clk, .reset, .translate,
    .vpn(vAdr[xlen-1:pageOffsetBits]),
    .asid(satp[satpAsidLsb +: asidBits]),
    .privilegeMode, .statusMxr, .statusSum,
    .executeAccess, .readAccess, .writeAccess,
    .pte, .pageTypeWriteVal, .tlbWrite, .tlbFlush,
    .tlbPpn, .tlbHit, .tlbMiss, .tlbPageFault
  );

  // Page offset never changes
  assign physicalAddress = translate ? {tlbPpn, vAdr[pageOffsetBits-1:0]}
                                     : {{(paBits-xlen){1'b0}}, vAdr};
  assign adrValid = ~translate | tlbHit;

  //////////////////////////////////////////////////
  // Physical checks
  //////////////////////////////////////////////////

  pmaChecker pmaChecker_inst (
    .physicalAddress, .executeAccess, .readAccess, .writeAccess, .atomicAccess,
    .cacheable, .idempotent, .pmaFaults
  );

  pmpChecker pmpChecker_inst (
    .physicalAddress, .privilegeMode, .pmpCfg, .pmpAddr,
    .executeAccess, .readAccess, .writeAccess, .pmpFaults
  );

  // Checkers see a stale PA on a miss
  assign accessFaults = (pmaFaults | pmpFaults) & {3{~tlbMiss}};

  always_comb begin
    case (size)
      sizeByte:   dataMisaligned = 1'b0;
      sizeHalf:   dataMisaligned = vAdr[0];
      sizeWord:   dataMisaligned = |vAdr[1:0];
      sizeDouble: dataMisaligned = |vAdr[2:0];
      default:    dataMisaligned = 1'b0;
    endcase
  end

  assign readNoAmo = readAccess & ~writeAccess;

  //////////////////////////////////////////////////
  // Fault merge
  //////////////////////////////////////////////////

  always_comb begin
    faults.instrAccess     = accessFaults[faultInstr];
    faults.loadAccess      = accessFaults[faultLoad];
    faults.storeAccess     = accessFaults[faultStore];
    faults.instrPage       = tlbPageFault & executeAccess;
    faults.loadPage        = tlbPageFault & readNoAmo;
    faults.storePage       = tlbPageFault & writeAccess;
    faults.loadMisaligned  = dataMisaligned & readNoAmo & ~cacheable & adrValid;   // RAM splits in cache
    faults.storeMisaligned = dataMisaligned & writeAccess & ~cacheable & adrValid;
    faults.tlbMiss         = tlbMiss;
  end

endmodule

/* rtl/mmuPkg.sv */
// Shared widths, types and constants of the Sv32 MMU; imported by every RTL module
package mmuPkg;

  //////////////////////////////////////////////////
  // Widths and counts
  //////////////////////////////////////////////////

  localparam int xlen           = 32;                  // Core data and virtual address width
  localparam int paBits         = 34;                  // Sv32 physical address width
  localparam int pageOffsetBits = 12;                  // 4 KiB page offset
  localparam int vpnLowBits     = 10;                  // VPN[0] field, passed through on megapages
  localparam int tlbEntries     = 4;
  localparam int tlbIdxBits     = $clog2(tlbEntries);  // Victim pointer width
  localparam int pmpEntries     = 4;
  localparam int asidBits       = 9;
  localparam int satpModeBit    = 31;                  // Sv32 enable in satp
  localparam int satpAsidLsb    = 22;                  // ASID field base in satp

  // Bit positions inside a three-bit fault group
  localparam int faultInstr = 2;
  localparam int faultLoad  = 1;
  localparam int faultStore = 0;

  // pmpcfg byte layout
  localparam int pmpLBit = 7;                  // Lock, also enforces in M-mode
  localparam int pmpAHi  = 4;
  localparam int pmpALo  = 3;
  localparam int pmpXBit = 2;
  localparam int pmpWBit = 1;
  localparam int pmpRBit = 0;
  localparam logic [1:0] pmpTor = 2'b01;       // Only address mode supported

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  typedef logic [xlen-1:0]                  vAdrT;
  typedef logic [paBits-1:0]                pAdrT;
  typedef logic [paBits-pageOffsetBits-1:0] ppnT;     // 22 bits
  typedef logic [xlen-pageOffsetBits-1:0]   vpnT;     // 20 bits
  typedef logic [asidBits-1:0]              asidT;
  typedef logic [paBits-3:0]                pmpAddrT; // PA[33:2]
  typedef logic [7:0]                       pmpCfgT;  // L, rsvd, A, X, W, R

  // Sv32 page table entry, same bit order as in memory
  typedef struct packed {
    ppnT        ppn;
    logic [1:0] rsw;                           // Free for software
    logic       d;
    logic       a;
    logic       g;
    logic       u;
    logic       x;
    logic       w;
    logic       r;
    logic       v;
  } pteT;

  typedef struct packed {
    logic instrAccess;
    logic loadAccess;
    logic storeAccess;                         // Store or AMO
    logic instrPage;
    logic loadPage;
    logic storePage;
    logic loadMisaligned;
    logic storeMisaligned;
    logic tlbMiss;                             // Walker must refill before retry
  } mmuFaultsT;

  typedef enum logic [1:0] {
    privUser       = 2'b00,
    privSupervisor = 2'b01,
    privMachine    = 2'b11
  } privModeT;

  typedef enum logic [1:0] {
    sizeByte   = 2'b00,
    sizeHalf   = 2'b01,
    sizeWord   = 2'b10,
    sizeDouble = 2'b11
  } accessSizeT;

  // Fixed physical memory map
  localparam pAdrT pmaRamBase = 34'h8000_0000; // 128 MiB main memory
  localparam pAdrT pmaRamMask = 34'h07FF_FFFF;
  localparam pAdrT pmaIoBase  = 34'h1000_0000; // 256 MiB peripherals
  localparam pAdrT pmaIoMask  = 34'h0FFF_FFFF;

endpackage

/* rtl/pmaChecker.sv */
// Physical memory attribute check against the fixed map; gives attributes and access faults
module pmaChecker (
  input  mmuPkg::pAdrT physicalAddress,
  input  logic         executeAccess,
  input  logic         readAccess,
  input  logic         writeAccess,
  input  logic         atomicAccess,
  output logic         cacheable,
  output logic         idempotent,
  output logic [2:0]   pmaFaults        // Instr, load, store/AMO
);
  import mmuPkg::*;

  logic inRam;
  logic inIo;
  logic mapped;
  logic storeLike;

  //////////////////////////////////////////////////
  // Region decode
  //////////////////////////////////////////////////

  assign inRam  = (physicalAddress & ~pmaRamMask) == pmaRamBase;
  assign inIo   = (physicalAddress & ~pmaIoMask) == pmaIoBase;
  assign mapped = inRam | inIo;   // Anything else is a hole

  // Only main memory may be cached or replayed
  assign cacheable  = inRam;
  assign idempotent = inRam;

  // AMOs report as stores
  assign storeLike = writeAccess | atomicAccess;

  //////////////////////////////////////////////////
  // Faults
  //////////////////////////////////////////////////

  // Fetch only from RAM
  assign pmaFaults[faultInstr] = executeAccess & ~inRam;
  assign pmaFaults[faultLoad]  = readAccess & ~mapped;
  // Peripherals have no atomic support
  assign pmaFaults[faultStore] = storeLike & (~mapped | (inIo & atomicAccess));

endmodule

/* rtl/pmpChecker.sv */
// Physical memory protection over four TOR entries; gives PMP access faults to mmu
module pmpChecker (
  input  mmuPkg::pAdrT                               physicalAddress,
  input  mmuPkg::privModeT                           privilegeMode,
  input  mmuPkg::pmpCfgT  [mmuPkg::pmpEntries-1:0]   pmpCfg,
  input  mmuPkg::pmpAddrT [mmuPkg::pmpEntries-1:0]   pmpAddr,
  input  logic                                       executeAccess,
  input  logic                                       readAccess,
  input  logic                                       writeAccess,
  output logic [2:0]                                 pmpFaults  // Instr, load, store/AMO
);
  import mmuPkg::*;

  pmpAddrT                   adrWord;     // Word address, compares directly with pmpaddr
  pmpAddrT [pmpEntries-1:0]  lowBound;
  logic    [pmpEntries-1:0]  entryMatch;
  pmpCfgT                    matchCfg;
  logic                      anyMatch;
  logic                      machine;
  logic                      enforce;
  logic    [2:0]             request;
  logic    [2:0]             allowed;

  assign adrWord = physicalAddress[paBits-1:2];

  // Entry i spans [pmpaddr[i-1], pmpaddr[i]), entry 0 starts at zero
  assign lowBound = {pmpAddr[pmpEntries-2:0], pmpAddrT'(0)};

  //////////////////////////////////////////////////
  // Range match
  //////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < pmpEntries; i++) begin
      entryMatch[i] = (pmpCfg[i][pmpAHi:pmpALo] == pmpTor)  // OFF entries never match
                    & (adrWord >= lowBound[i])
                    & (adrWord < pmpAddr[i]);
    end
  end

  // Lowest-numbered match decides
  always_comb begin
    matchCfg = '0;
    for (int i = pmpEntries - 1; i >= 0; i--) begin
      if (entryMatch[i]) begin
        matchCfg = pmpCfg[i];
      end
    end
  end

  assign anyMatch = |entryMatch;
  assign machine  = privilegeMode == privMachine;
  assign enforce  = ~machine | matchCfg[pmpLBit];  // Lock binds M-mode too

  //////////////////////////////////////////////////
  // Decision
  //////////////////////////////////////////////////

  assign request[faultInstr] = executeAccess;
  assign request[faultLoad]  = readAccess;
  assign request[faultStore] = writeAccess;

  assign allowed[faultInstr] = matchCfg[pmpXBit];
  assign allowed[faultLoad]  = matchCfg[pmpRBit];
  assign allowed[faultStore] = matchCfg[pmpWBit];

  // No match: M-mode passes, S/U denied
  assign pmpFaults = anyMatch ? (request & ~allowed & {3{enforce}})
                              : (request & {3{~machine}});

endmodule

/* rtl/tlb.sv */
// Four-entry fully associative Sv32 TLB; refilled by an external walker, looked up by mmu
module tlb (
  input  logic             clk,
  input  logic             reset,
  input  logic             translate,        // Sv32 active for this access
  input  mmuPkg::vpnT      vpn,              // Lookup and refill tag
  input  mmuPkg::asidT     asid,
  input  mmuPkg::privModeT privilegeMode,
  input  logic             statusMxr,        // Loads may use X-only pages
  input  logic             statusSum,        // S-mode may touch U pages
  input  logic             executeAccess,
  input  logic             readAccess,
  input  logic             writeAccess,
  input  mmuPkg::pteT      pte,              // Leaf PTE from the walker
  input  logic             pageTypeWriteVal, // 1 = megapage
  input  logic             tlbWrite,         // Refill strobe
  input  logic             tlbFlush,         // sfence.vma, drops everything
  output mmuPkg::ppnT      tlbPpn,
  output logic             tlbHit,
  output logic             tlbMiss,
  output logic             tlbPageFault
);
  import mmuPkg::*;

  vpnT                   entryVpn  [tlbEntries];
  asidT                  entryAsid [tlbEntries];
  pteT                   entryPte  [tlbEntries];
  logic [tlbEntries-1:0] entryMega;
  logic [tlbEntries-1:0] entryValid;
  logic [tlbIdxBits-1:0] victim;     // Round-robin replacement
  logic [tlbEntries-1:0] match;
  logic                  anyMatch;
  pteT                   hitPte;
  logic                  hitMega;
  logic                  userFault, readFault, writeFault, execFault;
  logic                  adFault, alignFault;

  //////////////////////////////////////////////////
  // Entry storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      entryValid <= '0;
      victim     <= '0;
    end else if (tlbFlush) begin            // Flush wins over a same-cycle write
      entryValid <= '0;
    end else if (tlbWrite) begin
      entryValid[victim] <= 1'b1;
      victim             <= victim + 1'b1;  // Wraps over all entries
    end
  end

  // Tag and PTE payload
  always_ff @(posedge clk) begin
    if (tlbWrite & ~tlbFlush) begin
      entryVpn[victim]  <= vpn;
      entryAsid[victim] <= asid;
      entryPte[victim]  <= pte;
      entryMega[victim] <= pageTypeWriteVal;
    end
  end

  //////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < tlbEntries; i++) begin
      match[i] = entryValid[i]
               & (entryPte[i].g | (entryAsid[i] == asid))                          // Global skips ASID
               & (entryVpn[i][$bits(vpnT)-1:vpnLowBits] == vpn[$bits(vpnT)-1:vpnLowBits])
               & (entryMega[i] | (entryVpn[i][vpnLowBits-1:0] == vpn[vpnLowBits-1:0]));
    end
  end

  // Lowest matching index wins if software left duplicates
  always_comb begin
    hitPte  = '0;
    hitMega = 1'b0;
    for (int i = tlbEntries - 1; i >= 0; i--) begin
      if (match[i]) begin
        hitPte  = entryPte[i];
        hitMega = entryMega[i];
      end
    end
  end

  assign anyMatch = |match;
  assign tlbHit   = translate & anyMatch;
  assign tlbMiss  = translate & ~anyMatch;

  // Megapage keeps VPN[0] from the virtual address
  assign tlbPpn = hitMega ? {hitPte.ppn[$bits(ppnT)-1:vpnLowBits], vpn[vpnLowBits-1:0]}
                          : hitPte.ppn;

  //////////////////////////////////////////////////
  // Permission check
  //////////////////////////////////////////////////

  assign userFault  = ((privilegeMode == privUser) & ~hitPte.u)
                    | ((privilegeMode == privSupervisor) & hitPte.u
                       & (executeAccess | ~statusSum));   // SUM never covers fetch
  assign readFault  = readAccess & ~(hitPte.r | (statusMxr & hitPte.x));
  assign writeFault = writeAccess & ~hitPte.w;
  assign execFault  = executeAccess & ~hitPte.x;
  assign adFault    = ~hitPte.a | (writeAccess & ~hitPte.d); // No hardware A/D update
  assign alignFault = hitMega & (|hitPte.ppn[vpnLowBits-1:0]);

  assign tlbPageFault = tlbHit & (userFault | readFault | writeFault | execFault
                                  | adFault | alignFault);

endmodule

/* verification/mmuTb.sv */
// Testbench for the Sv32 MMU; drives bypass, refill, fault and random accesses for the bound checks
module mmuTb;
  timeunit 1ns;
  timeprecision 100ps;
  import mmuPkg::*;

  localparam int clkPeriod      = 10;
  localparam int resetCycles    = 10;
  localparam int randomAccesses = 300;                                  // Per random phase
  localparam int stimCycles     = resetCycles + 2 * randomAccesses + 150; // Directed part < 150
  localparam int timeoutNs      = stimCycles * clkPeriod + 500;

  // Access kinds
  localparam logic [1:0] kindExec  = 2'd0;
  localparam logic [1:0] kindLoad  = 2'd1;
  localparam logic [1:0] kindStore = 2'd2;
  localparam logic [1:0] kindAmo   = 2'd3;

  // PTE flag byte: D A G U X W R V
  localparam logic [7:0] flagsAll  = 8'hCF;   // D A X W R V
  localparam logic [7:0] flagsNoW  = 8'hC3;
  localparam logic [7:0] flagsNoD  = 8'h47;
  localparam logic [7:0] flagsXOnly = 8'hC9;
  localparam logic [7:0] flagsUser = 8'hDF;
  localparam logic [7:0] flagsGlob = 8'hEF;

  logic                     clk = 1'b0;
  logic                     reset;
  logic [xlen-1:0]          satp;
  logic                     statusMxr, statusSum, disableTranslation;
  privModeT                 privilegeMode;
  vAdrT                     vAdr;
  accessSizeT               size;
  pteT                      pte;
  logic                     pageTypeWriteVal, tlbWrite, tlbFlush;
  logic                     executeAccess, readAccess, writeAccess, atomicAccess;
  pmpCfgT  [pmpEntries-1:0] pmpCfg;
  pmpAddrT [pmpEntries-1:0] pmpAddr;
  pAdrT                     physicalAddress;
  logic                     cacheable, idempotent;
  mmuFaultsT                faults;
  int                       accessCount = 0;
  int                       errors;

  always #(clkPeriod / 2) clk = ~clk;

  mmu mmu_inst (.*);
  bind mmu mmu_asserts assertsInst (.*);

  function automatic pteT makePte(input ppnT ppn, input logic [7:0] flags);
    return pteT'({ppn, 2'b00, flags});
  endfunction

  // One access, driven just after the edge and held a cycle
  task automatic access(input vAdrT adr, input accessSizeT sz, input logic [1:0] kind,
                        input privModeT priv);
    @(posedge clk);
    #1;
    vAdr          = adr;
    size          = sz;
    privilegeMode = priv;
    executeAccess = kind == kindExec;
    readAccess    = kind == kindLoad || kind == kindAmo;
    writeAccess   = kind == kindStore || kind == kindAmo;
    atomicAccess  = kind == kindAmo;
    accessCount++;
  endtask

  // Flush, then write one entry; the cycle after the flush looks up the same page
  task automatic refill(input vAdrT adr, input pteT entry, input logic mega);
    @(posedge clk);
    #1;
    tlbFlush = 1'b1;
    @(posedge clk);
    #1;
    tlbFlush         = 1'b0;
    vAdr             = adr;
    pte              = entry;
    pageTypeWriteVal = mega;
    tlbWrite         = 1'b1;
    @(posedge clk);
    #1;
    tlbWrite = 1'b0;
  endtask

  // RAM, I/O and unmapped addresses with random sizes and kinds
  task automatic randomBypass(input int count, input logic machineOnly);
    vAdrT     adr;
    privModeT priv;
    int       pick;
    for (int n = 0; n < count; n++) begin
      pick = $urandom_range(3, 0);
      case (pick)
        0:       adr = 32'h8000_0000 | ($urandom & 32'h007F_FFFF);  // Across all TOR ranges
        1:       adr = 32'h1000_0000 | ($urandom & 32'h0FFF_FFFF);
        2:       adr = 32'h4000_0000 | ($urandom & 32'h0FFF_FFFF);  // Hole
        default: adr = 32'h8000_0000 | ($urandom & 32'h003F_FFFF);
      endcase
      pick = $urandom_range(2, 0);
      priv = (pick == 0) ? privUser : (pick == 1) ? privSupervisor : privMachine;
      if (machineOnly) priv = privMachine;
      access(adr, accessSizeT'($urandom_range(3, 0)), 2'($urandom_range(3, 0)), priv);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(71168));
    reset = 1'b1;
    satp = '0;                                // Bare
    statusMxr = 1'b0;
    statusSum = 1'b0;
    disableTranslation = 1'b0;
    privilegeMode = privMachine;
    vAdr = '0;
    size = sizeWord;
    pte = '0;
    pageTypeWriteVal = 1'b0;
    tlbWrite = 1'b0;
    tlbFlush = 1'b0;
    executeAccess = 1'b0;
    readAccess = 1'b1;
    writeAccess = 1'b0;
    atomicAccess = 1'b0;
    pmpCfg  = {8'h08, 8'h89, 8'h0F, 8'h0B};     // None, locked R, RWX, RW
    pmpAddr = {32'h2010_0000, 32'h2008_0000, 32'h2004_0000, 32'h2000_0000};
    repeat (resetCycles) @(posedge clk);
    #1;
    reset = 1'b0;

    randomBypass(randomAccesses, 1'b0);       // satp bare
    satp = 32'h8000_0000 | (32'd5 << 22);     // Sv32, ASID 5
    randomBypass(randomAccesses, 1'b1);       // M-mode ignores satp

    // Refill and hit, global entry survives an ASID change
    refill(32'h0040_1000, makePte(22'h80050, flagsGlob), 1'b0);
    access(32'h0040_1234, sizeWord, kindLoad, privSupervisor);
    access(32'h0040_1238, sizeWord, kindStore, privSupervisor);
    satp = 32'h8000_0000 | (32'd6 << 22);
    access(32'h0040_1ABC, sizeWord, kindExec, privSupervisor);
    satp = 32'h8000_0000 | (32'd5 << 22);
    refill(32'h0041_2000, makePte(22'h80051, flagsNoW), 1'b0);
    access(32'h0041_2008, sizeWord, kindStore, privSupervisor);
    refill(32'h0042_3000, makePte(22'h80052, flagsNoD), 1'b0);
    access(32'h0042_3010, sizeWord, kindStore, privSupervisor);
    access(32'h0042_3010, sizeWord, kindLoad, privSupervisor);

    // X-only page, with and without MXR
    refill(32'h0043_4000, makePte(22'h80053, flagsXOnly), 1'b0);
    access(32'h0043_4020, sizeWord, kindLoad, privSupervisor);
    statusMxr = 1'b1;
    access(32'h0043_4020, sizeWord, kindLoad, privSupervisor);
    access(32'h0043_4024, sizeWord, kindExec, privSupervisor);
    access(32'h0043_4028, sizeWord, kindAmo, privSupervisor);
    statusMxr = 1'b0;

    // U bit against the privilege
    refill(32'h0044_5000, makePte(22'h80054, flagsAll), 1'b0);
    access(32'h0044_5000, sizeWord, kindExec, privUser);
    access(32'h0044_5004, sizeWord, kindLoad, privUser);
    access(32'h0044_5008, sizeWord, kindStore, privUser);
    refill(32'h0045_6000, makePte(22'h80055, flagsUser), 1'b0);
    access(32'h0045_6000, sizeWord, kindLoad, privSupervisor);
    statusSum = 1'b1;
    access(32'h0045_6000, sizeWord, kindLoad, privSupervisor);
    access(32'h0045_6004, sizeWord, kindExec, privSupervisor);   // SUM never covers fetch
    statusSum = 1'b0;

    // Megapages, aligned and not
    refill(32'h00C0_0000, makePte(22'h80000, flagsAll), 1'b1);
    access(32'h00C0_5678, sizeWord, kindLoad, privSupervisor);
    access(32'h00D2_3454, sizeWord, kindStore, privSupervisor);  // Lands in locked R range
    refill(32'h0100_0000, makePte(22'h80001, flagsAll), 1'b1);
    access(32'h0100_0040, sizeWord, kindLoad, privSupervisor);

    // Page mapped onto I/O
    refill(32'h0050_0000, makePte(22'h10000, flagsAll), 1'b0);
    access(32'h0050_0001, sizeHalf, kindStore, privSupervisor);
    access(32'h0050_0006, sizeWord, kindLoad, privSupervisor);
    access(32'h0050_0010, sizeWord, kindExec, privSupervisor);
    access(32'h0050_0020, sizeWord, kindAmo, privSupervisor);
    disableTranslation = 1'b1;
    access(32'h8030_0004, sizeWord, kindStore, privSupervisor);
    disableTranslation = 1'b0;

    repeat (2) @(posedge clk);
    #1;
    errors = mmu_inst.assertsInst.failCount;
    $display("Accesses: %0d, assertion failures: %0d", accessCount, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(timeoutNs);
    $display("Timeout: stimulus did not complete within %0d ns", timeoutNs);
    $display("Checks failed");
    $finish;
  end

endmodule

/* verification/mmu_asserts.sv */
// Concurrent checks bound into the MMU; a shadow of the last TLB refill gives expected hits
module mmu_asserts (
  input logic                                     clk,
  input logic                                     reset,
  input logic [mmuPkg::xlen-1:0]                  satp,
  input logic                                     statusMxr,
  input logic                                     statusSum,
  input mmuPkg::privModeT                         privilegeMode,
  input logic                                     disableTranslation,
  input mmuPkg::vAdrT                             vAdr,
  input mmuPkg::accessSizeT                       size,
  input mmuPkg::pteT                              pte,
  input logic                                     pageTypeWriteVal,
  input logic                                     tlbWrite,
  input logic                                     tlbFlush,
  input logic                                     executeAccess,
  input logic                                     readAccess,
  input logic                                     writeAccess,
  input logic                                     atomicAccess,
  input mmuPkg::pmpCfgT  [mmuPkg::pmpEntries-1:0] pmpCfg,
  input mmuPkg::pmpAddrT [mmuPkg::pmpEntries-1:0] pmpAddr,
  input mmuPkg::pAdrT                             physicalAddress,
  input logic                                     cacheable,
  input logic                                     idempotent,
  input mmuPkg::mmuFaultsT                        faults
);
  timeunit 1ns;
  timeprecision 100ps;
  import mmuPkg::*;

  vpnT        shadowVpn;
  asidT       shadowAsid;
  pteT        shadowPte;
  logic       shadowMega;
  logic       shadowValid;         // Cleared by flush, like the TLB
  logic       translateExp, shadowHit, pageFaultExp, misExp;
  logic       inRam, inIo, unmapped;
  logic [2:0] lowBits;             // Address bits that must be zero for the size
  logic [2:0] accessBits, pageBits, pmpExp, pageExp;
  logic [2:0] ioExp;               // I/O region rules: no fetch, no AMO
  logic [1:0] misBits, misExpBits;
  pAdrT       expPa;
  int         failCount = 0;      // Read by the testbench at the end

  // First TOR entry that covers the address decides; no match only passes M-mode
  function automatic logic [2:0] pmpFaultsFor(input pAdrT pa, input privModeT priv,
                                               input pmpCfgT [pmpEntries-1:0] cfg,
                                               input pmpAddrT [pmpEntries-1:0] top,
                                               input logic ex, input logic rd, input logic wr);
    pmpAddrT    lo;
    logic [2:0] req;
    req = {ex, rd, wr};
    lo  = '0;
    for (int i = 0; i < pmpEntries; i++) begin
      if (cfg[i][4:3] == 2'b01 && pa[paBits-1:2] >= lo && pa[paBits-1:2] < top[i]) begin
        if (priv == privMachine && !cfg[i][7]) return 3'b000;  // Unlocked, M ignores
        return req & ~{cfg[i][2], cfg[i][0], cfg[i][1]};
      end
      lo = top[i];
    end
    return (priv == privMachine) ? 3'b000 : req;
  endfunction

  // Sv32 leaf permission rules, no hardware A/D update
  function automatic logic pageFaultFor(input pteT p, input logic mega, input privModeT priv,
                                        input logic sum, input logic mxr,
                                        input logic ex, input logic rd, input logic wr);
    logic userBad;
    userBad = (priv == privUser) ? !p.u : (p.u && (ex || !sum));
    return userBad || (rd && !(p.r || (mxr && p.x))) || (wr && !p.w) || (ex && !p.x)
        || !p.a || (wr && !p.d) || (mega && p.ppn[vpnLowBits-1:0] != '0);
  endfunction

  //////////////////////////////////////////////////
  // Shadow of the last refill
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || tlbFlush) begin
      shadowValid <= 1'b0;
    end else if (tlbWrite) begin
      shadowValid <= 1'b1;
      shadowVpn   <= vAdr[xlen-1:pageOffsetBits];
      shadowAsid  <= satp[30:22];
      shadowPte   <= pte;
      shadowMega  <= pageTypeWriteVal;
    end
  end

  assign translateExp = satp[31] && privilegeMode != privMachine && !disableTranslation;
  assign shadowHit = shadowValid && translateExp
                  && (shadowPte.g || shadowAsid == satp[30:22])
                  && (shadowMega ? shadowVpn[19:10] == vAdr[31:22]
                                 : shadowVpn == vAdr[31:12]);
  assign expPa = shadowMega ? {shadowPte.ppn[21:10], vAdr[21:0]}   // VPN[0] passes through
                            : {shadowPte.ppn, vAdr[11:0]};
  assign pageFaultExp = pageFaultFor(shadowPte, shadowMega, privilegeMode, statusSum, statusMxr,
                                     executeAccess, readAccess, writeAccess);
  assign pageExp = {pageFaultExp & executeAccess, pageFaultExp & readAccess & ~writeAccess,
                    pageFaultExp & writeAccess};

  // Region map taken as address ranges
  assign inRam    = physicalAddress >= pmaRamBase && physicalAddress <= pmaRamBase + pmaRamMask;
  assign inIo     = physicalAddress >= pmaIoBase && physicalAddress <= pmaIoBase + pmaIoMask;
  assign unmapped = !inRam && !inIo;
  assign pmpExp   = pmpFaultsFor(physicalAddress, privilegeMode, pmpCfg, pmpAddr,
                                 executeAccess, readAccess, writeAccess);
  assign ioExp    = inIo ? {executeAccess, 1'b0, atomicAccess} : 3'b000;

  always_comb begin
    case (size)
      sizeHalf:   lowBits = 3'b001;
      sizeWord:   lowBits = 3'b011;
      sizeDouble: lowBits = 3'b111;
      default:    lowBits = 3'b000;
    endcase
  end

  assign misExp     = |(vAdr[2:0] & lowBits);
  assign misExpBits = {misExp & readAccess & ~writeAccess & ~inRam, misExp & writeAccess & ~inRam};
  assign misBits    = {faults.loadMisaligned, faults.storeMisaligned};
  assign accessBits = {faults.instrAccess, faults.loadAccess, faults.storeAccess};
  assign pageBits   = {faults.instrPage, faults.loadPage, faults.storePage};

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  bypassPa: assert property (@(posedge clk) disable iff (reset)
    !translateExp |-> physicalAddress == pAdrT'(vAdr))
    else begin
      failCount++;
      $error("Fail physicalAddress got %h expected %h", $sampled(physicalAddress),
             pAdrT'($sampled(vAdr)));
    end
  bypassNoMiss: assert property (@(posedge clk) disable iff (reset)
    !translateExp |-> !faults.tlbMiss)
    else begin
      failCount++;
      $error("Fail faults.tlbMiss got %h expected %h", $sampled(faults.tlbMiss), 1'b0);
    end
  // Nothing valid right after reset or a flush
  emptyMiss: assert property (@(posedge clk) disable iff (reset)
    ($past(tlbFlush) || $past(reset)) && translateExp |-> faults.tlbMiss)
    else begin
      failCount++;
      $error("Fail faults.tlbMiss got %h expected %h", $sampled(faults.tlbMiss), 1'b1);
    end
  missMasks: assert property (@(posedge clk) disable iff (reset)
    faults.tlbMiss |-> accessBits == 3'b000)
    else begin
      failCount++;
      $error("Fail faults.access got %h expected %h", $sampled(accessBits), 3'b000);
    end
  refillHit: assert property (@(posedge clk) disable iff (reset)
    shadowHit |-> !faults.tlbMiss && physicalAddress == expPa)
    else begin
      failCount++;
      $error("Fail physicalAddress got %h expected %h (tlbMiss %h)",
             $sampled(physicalAddress), $sampled(expPa), $sampled(faults.tlbMiss));
    end
  pagePerm: assert property (@(posedge clk) disable iff (reset)
    shadowHit |-> pageBits == pageExp)
    else begin
      failCount++;
      $error("Fail faults.page got %h expected %h", $sampled(pageBits), $sampled(pageExp));
    end
  misalign: assert property (@(posedge clk) disable iff (reset)
    !faults.tlbMiss |-> misBits == misExpBits)
    else begin
      failCount++;
      $error("Fail faults.misaligned got %h expected %h", $sampled(misBits), $sampled(misExpBits));
    end
  unmappedAccess: assert property (@(posedge clk) disable iff (reset)
    !faults.tlbMiss && unmapped |->
      accessBits == {executeAccess, readAccess, writeAccess | atomicAccess})
    else begin
      failCount++;
      $error("Fail faults.access got %h for unmapped address %h", $sampled(accessBits),
             $sampled(physicalAddress));
    end
  ioExecute: assert property (@(posedge clk) disable iff (reset)
    !faults.tlbMiss && inIo && executeAccess |-> faults.instrAccess)
    else begin
      failCount++;
      $error("Fail faults.instrAccess got %h expected %h", $sampled(faults.instrAccess), 1'b1);
    end
  // RAM and I/O both go through PMP, I/O adds its own limits
  mappedPmp: assert property (@(posedge clk) disable iff (reset)
    !faults.tlbMiss && !unmapped |-> accessBits == (pmpExp | ioExp))
    else begin
      failCount++;
      $error("Fail faults.access got %h expected %h", $sampled(accessBits),
             $sampled(pmpExp | ioExp));
    end
  attributes: assert property (@(posedge clk) disable iff (reset)
    cacheable == inRam && idempotent == inRam)
    else begin
      failCount++;
      $error("Fail cacheable got %h expected %h", $sampled(cacheable), $sampled(inRam));
    end

endmodule
